// ==== design/soc_pkg.sv ====
package soc_pkg;

	typedef enum logic [3:0] {
		LDI  = 4'h0,
		LD   = 4'h1,
		ST   = 4'h2,
		ADD  = 4'h3,
		SUB  = 4'h4,
		AND  = 4'h5,
		OR   = 4'h6,
		XOR  = 4'h7,
		JMP  = 4'h8,
		JZ   = 4'h9,
		HALT = 4'hA
	} opcode_t; // 4'hB..4'hF trap

	typedef struct packed {
		opcode_t opcode;
		logic [7:0] operand; // Address, program address or immediate
	} instr_t;

	typedef struct packed {
		logic [7:0] addr;
		logic [7:0] wdata;
		logic we;
		logic re;
	} bus_req_t;

	typedef struct packed {
		logic we;
		logic [7:0] addr;
		instr_t instr;
	} prog_load_t;

	// Port 0 in the low byte, so a cast to [2:0][7:0] indexes by port
	typedef struct packed {
		logic [7:0] port2;
		logic [7:0] port1;
		logic [7:0] port0;
	} gpio_pins_t;

	typedef struct packed {
		logic pc_load;
		logic pc_inc;
		logic ir_load;
		logic acc_load;
		logic acc_from_mem; // Accumulator takes bus read data
		opcode_t alu_op;
	} ctl_t;

	localparam logic [7:0] GPIO_BASE = 8'h80;
	localparam int GPIO_REGS = 6; // Data and direction per port

endpackage

// ==== design/clock_enable.sv ====
`timescale 1ns/1ps

module clock_enable #(parameter int CLKDIV = 4) (
	input logic clk,
	input logic reset,
	output logic tick
);
	localparam int CW = (CLKDIV > 1) ? $clog2(CLKDIV) : 1;

	logic [CW-1:0] count;
	logic [CW-1:0] count_next;

	always_comb begin
		if (count == '0)
			count_next = CW'(CLKDIV - 1); // Reload on expiry
		else
			count_next = count - 1'b1;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			count <= '0;
			tick <= 1'b0;
		end else begin
			count <= count_next;
			tick <= (count_next == '0); // One cycle per period
		end
	end

endmodule

// ==== design/cpu_control.sv ====
`timescale 1ns/1ps

module cpu_control (
	input logic clk,
	input logic reset,
	input logic tick,
	input soc_pkg::instr_t instr,
	input logic zero,
	input logic [7:0] acc,
	output soc_pkg::ctl_t ctl,
	output soc_pkg::bus_req_t bus_req,
	output logic halted,
	output logic trap
);
	typedef enum logic [1:0] {
		FETCH,
		EXECUTE,
		WRITEBACK,
		STOP
	} state_t;

	state_t state;
	state_t state_next;
	logic halt_hit;
	logic trap_hit;

	always_comb begin
		ctl = '0;
		ctl.alu_op = instr.opcode;
		bus_req = '0;
		bus_req.addr = instr.operand;
		bus_req.wdata = acc; // Only ST writes
		state_next = state;
		halt_hit = 1'b0;
		trap_hit = 1'b0;
		case (state)
			FETCH: begin
				ctl.ir_load = 1'b1;
				ctl.pc_inc = 1'b1;
				state_next = EXECUTE;
			end
			EXECUTE: begin
				state_next = FETCH;
				case (instr.opcode)
					soc_pkg::LDI, soc_pkg::ADD, soc_pkg::SUB,
					soc_pkg::AND, soc_pkg::OR, soc_pkg::XOR: begin
						ctl.acc_load = 1'b1;
					end
					soc_pkg::LD: begin
						bus_req.re = 1'b1;
						state_next = WRITEBACK; // Data arrives next tick
					end
					soc_pkg::ST: bus_req.we = 1'b1;
					soc_pkg::JMP: ctl.pc_load = 1'b1;
					soc_pkg::JZ: ctl.pc_load = zero;
					soc_pkg::HALT: begin
						halt_hit = 1'b1;
						state_next = STOP;
					end
					default: begin
						trap_hit = 1'b1; // Illegal opcode
						state_next = STOP;
					end
				endcase
			end
			WRITEBACK: begin
				ctl.acc_load = 1'b1;
				ctl.acc_from_mem = 1'b1;
				state_next = FETCH;
			end
			default: state_next = STOP; // Held until reset
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= FETCH;
			halted <= 1'b0;
			trap <= 1'b0;
		end else if (tick) begin
			state <= state_next;
			if (halt_hit)
				halted <= 1'b1;
			if (trap_hit)
				trap <= 1'b1;
		end
	end

endmodule

// ==== design/cpu_datapath.sv ====
`timescale 1ns/1ps

module cpu_datapath #(parameter int ROMSIZE = 256) (
	input logic clk,
	input logic reset,
	input logic tick,
	input soc_pkg::ctl_t ctl,
	input soc_pkg::instr_t fetch_instr,
	input logic [7:0] rdata,
	output logic [7:0] pc,
	output soc_pkg::instr_t instr,
	output logic [7:0] acc,
	output logic zero
);
	logic [7:0] pc_q;
	logic [8:0] pc_plus;
	logic [7:0] pc_wrap;
	logic [7:0] target;
	logic [7:0] alu_out;

	assign pc_plus = {1'b0, pc_q} + 9'd1;
	assign pc_wrap = (int'(pc_plus) == ROMSIZE) ? 8'h00 : pc_plus[7:0];
	assign target = 8'(int'(instr.operand) % ROMSIZE);

	// Fetch address looks ahead to a taken jump
	assign pc = ctl.pc_load ? target : pc_q;

	assign zero = (acc == 8'h00);

	always_comb begin
		case (ctl.alu_op)
			soc_pkg::LDI: alu_out = instr.operand;
			soc_pkg::ADD: alu_out = acc + instr.operand;
			soc_pkg::SUB: alu_out = acc - instr.operand;
			soc_pkg::AND: alu_out = acc & instr.operand;
			soc_pkg::OR: alu_out = acc | instr.operand;
			soc_pkg::XOR: alu_out = acc ^ instr.operand;
			default: alu_out = acc;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pc_q <= 8'h00;
			acc <= 8'h00;
		end else if (tick) begin
			if (ctl.pc_load)
				pc_q <= target;
			else if (ctl.pc_inc)
				pc_q <= pc_wrap;
			if (ctl.acc_load)
				acc <= ctl.acc_from_mem ? rdata : alu_out;
		end
	end

	always_ff @(posedge clk) begin
		if (tick && ctl.ir_load)
			instr <= fetch_instr;
	end

endmodule

// ==== design/memory_map.sv ====
`timescale 1ns/1ps

module memory_map #(
	parameter int ROMSIZE = 256,
	parameter int RAMSIZE = 128
) (
	input logic clk,
	input logic reset,
	input logic tick,
	input logic [7:0] pc,
	input soc_pkg::prog_load_t prog_load,
	input soc_pkg::bus_req_t bus_req,
	input logic [7:0] gpio_rdata,
	output soc_pkg::instr_t fetch_instr,
	output logic [7:0] rdata,
	output logic gpio_we,
	output logic [2:0] gpio_sel,
	output logic [7:0] gpio_wdata
);
	soc_pkg::instr_t prog_mem [ROMSIZE];
	logic [7:0] ram [RAMSIZE];
	logic load_we;
	logic ram_hit;
	logic gpio_hit;

	assign load_we = reset && prog_load.we && (int'(prog_load.addr) < ROMSIZE);

	assign ram_hit = int'(bus_req.addr) < RAMSIZE;
	assign gpio_hit = (bus_req.addr >= soc_pkg::GPIO_BASE) &&
		(int'(bus_req.addr) < int'(soc_pkg::GPIO_BASE) + soc_pkg::GPIO_REGS);

	assign gpio_sel = 3'(bus_req.addr - soc_pkg::GPIO_BASE); // {port, dir}
	assign gpio_we = bus_req.we && gpio_hit;
	assign gpio_wdata = bus_req.wdata;

	always_ff @(posedge clk) begin
		if (load_we)
			prog_mem[prog_load.addr] <= prog_load.instr;
		if (load_we && prog_load.addr == pc)
			fetch_instr <= prog_load.instr; // Write-through for the first fetch
		else if (tick || reset)
			fetch_instr <= prog_mem[pc];
	end

	always_ff @(posedge clk) begin
		if (tick && bus_req.we && ram_hit)
			ram[bus_req.addr[6:0]] <= bus_req.wdata;
	end

	always_ff @(posedge clk) begin
		if (tick && bus_req.re) begin
			if (ram_hit)
				rdata <= ram[bus_req.addr[6:0]];
			else if (gpio_hit)
				rdata <= gpio_rdata;
			else
				rdata <= 8'h00; // Unmapped
		end
	end

endmodule

// ==== design/gpio_ports.sv ====
`timescale 1ns/1ps

module gpio_ports (
	input logic clk,
	input logic reset,
	input logic tick,
	input logic gpio_we,
	input logic [2:0] gpio_sel,
	input logic [7:0] gpio_wdata,
	input soc_pkg::gpio_pins_t gpio_in,
	output logic [7:0] gpio_rdata,
	output soc_pkg::gpio_pins_t gpio_out,
	output soc_pkg::gpio_pins_t gpio_oe
);
	logic [2:0][7:0] data_q;
	logic [2:0][7:0] dir_q;
	logic [2:0][7:0] in_meta;
	logic [2:0][7:0] in_sync;
	logic [1:0] port;
	logic port_ok;

	assign port = gpio_sel[2:1];
	assign port_ok = (port != 2'd3);

	assign gpio_out = data_q;
	assign gpio_oe = dir_q;

	always_ff @(posedge clk) begin
		if (tick) begin
			in_meta <= gpio_in; // Two-stage synchronizer
			in_sync <= in_meta;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			data_q <= '0;
			dir_q <= '0;
		end else if (tick && gpio_we && port_ok) begin
			if (gpio_sel[0])
				dir_q[port] <= gpio_wdata;
			else
				data_q[port] <= gpio_wdata;
		end
	end

	always_comb begin
		gpio_rdata = 8'h00;
		if (port_ok) begin
			if (gpio_sel[0])
				gpio_rdata = dir_q[port];
			else
				gpio_rdata = (data_q[port] & dir_q[port]) | (in_sync[port] & ~dir_q[port]);
		end
	end

endmodule

// ==== design/soc_top.sv ====
`timescale 1ns/1ps

module soc_top #(
	parameter int ROMSIZE = 256,
	parameter int RAMSIZE = 128,
	parameter int CLKDIV = 4
) (
	input logic clk,
	input logic reset,
	input soc_pkg::prog_load_t prog_load,
	input soc_pkg::gpio_pins_t gpio_in,
	output soc_pkg::gpio_pins_t gpio_out,
	output soc_pkg::gpio_pins_t gpio_oe,
	output logic halted,
	output logic trap
);
	logic tick;
	soc_pkg::ctl_t ctl;
	soc_pkg::bus_req_t bus_req;
	soc_pkg::instr_t instr;
	soc_pkg::instr_t fetch_instr;
	logic zero;
	logic [7:0] acc;
	logic [7:0] pc;
	logic [7:0] rdata;
	logic gpio_we;
	logic [2:0] gpio_sel;
	logic [7:0] gpio_wdata;
	logic [7:0] gpio_rdata;

	clock_enable #(.CLKDIV(CLKDIV)) clock_enable(.*);
	cpu_control cpu_control(.*);
	cpu_datapath #(.ROMSIZE(ROMSIZE)) cpu_datapath(.*);
	memory_map #(.ROMSIZE(ROMSIZE), .RAMSIZE(RAMSIZE)) memory_map(.*);
	gpio_ports gpio_ports(.*);

endmodule

// ==== dv/soc_tb.sv ====
`timescale 1ns/1ps

module soc_tb;
	logic clk;
	logic reset;
	soc_pkg::prog_load_t prog_load;
	soc_pkg::gpio_pins_t gpio_in;
	soc_pkg::gpio_pins_t gpio_out;
	soc_pkg::gpio_pins_t gpio_oe;
	logic halted;
	logic trap;
	logic [31:0] lfsr_state;
	logic [11:0] prog [$]; // Program image for the next load

	soc_top #(.CLKDIV(4)) DUT(.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Galois LFSR with taps 32'hD0000001
	function automatic logic [7:0] rand_bits(input int n);
		logic [7:0] value;
		value = 8'h00;
		for (int i = 0; i < n; i++) begin
			if (lfsr_state[0])
				lfsr_state = (lfsr_state >> 1) ^ 32'hD000_0001;
			else
				lfsr_state = lfsr_state >> 1;
			value = {value[6:0], lfsr_state[0]};
		end
		return value;
	endfunction

	function automatic logic [11:0] encode(input soc_pkg::opcode_t op,
		input logic [7:0] operand);
		return {op, operand};
	endfunction

	task automatic check_value(input string what, input logic [23:0] got,
		input logic [23:0] exp);
		assert (got === exp) else begin
			$display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
			$display("Simulation failed");
			$fatal(1);
		end
	endtask

	// Writes the queued words under reset, then releases reset
	task automatic load_program();
		@(posedge clk);
		reset <= 1'b1;
		for (int i = 0; i < prog.size(); i++) begin
			@(posedge clk);
			prog_load <= {1'b1, 8'(i), prog[i]};
		end
		@(posedge clk);
		prog_load <= '0;
		repeat (2) @(posedge clk); // First fetch settles
		reset <= 1'b0;
		prog.delete();
	endtask

	task automatic wait_done(input int max_cycles);
		int n;
		n = 0;
		while (!(halted || trap) && n < max_cycles) begin
			@(negedge clk);
			n++;
		end
		if (!(halted || trap)) begin
			$display("timeout: program did not halt or trap within %0d cycles", max_cycles);
			$display("Simulation failed");
			$fatal(1);
		end
	endtask

	task automatic reset_defaults();
		prog.push_back(encode(soc_pkg::JMP, 8'h00)); // Spins in place
		load_program();
		repeat (40) begin
			@(negedge clk);
			check_value("gpio_oe after reset", gpio_oe, 24'h0);
			check_value("gpio_out after reset", gpio_out, 24'h0);
			check_value("halted after reset", 24'(halted), 24'h0);
			check_value("trap after reset", 24'(trap), 24'h0);
		end
	endtask

	task automatic alu_chain();
		logic [7:0] imm [8];
		logic [7:0] expected;
		for (int i = 0; i < 8; i++)
			imm[i] = rand_bits(8);
		expected = imm[0];
		expected = expected + imm[1];
		expected = expected - imm[2];
		expected = expected & imm[3];
		expected = expected | imm[4];
		expected = expected ^ imm[5];
		expected = expected + imm[6];
		expected = expected - imm[7];
		prog.push_back(encode(soc_pkg::LDI, 8'hFF));
		prog.push_back(encode(soc_pkg::ST, 8'h81));
		prog.push_back(encode(soc_pkg::LDI, imm[0]));
		prog.push_back(encode(soc_pkg::ADD, imm[1]));
		prog.push_back(encode(soc_pkg::SUB, imm[2]));
		prog.push_back(encode(soc_pkg::AND, imm[3]));
		prog.push_back(encode(soc_pkg::OR, imm[4]));
		prog.push_back(encode(soc_pkg::XOR, imm[5]));
		prog.push_back(encode(soc_pkg::ADD, imm[6]));
		prog.push_back(encode(soc_pkg::SUB, imm[7]));
		prog.push_back(encode(soc_pkg::ST, 8'h80));
		prog.push_back(encode(soc_pkg::HALT, 8'h00));
		load_program();
		wait_done(2000);
		check_value("alu result on port 0", 24'(gpio_out.port0), 24'(expected));
		check_value("port 0 direction", 24'(gpio_oe.port0), 24'hFF);
	endtask

	task automatic ram_round_trip();
		logic [7:0] stored [3];
		for (int i = 0; i < 3; i++)
			stored[i] = rand_bits(8);
		prog.push_back(encode(soc_pkg::LDI, 8'hFF));
		prog.push_back(encode(soc_pkg::ST, 8'h81));
		prog.push_back(encode(soc_pkg::ST, 8'h83));
		prog.push_back(encode(soc_pkg::ST, 8'h85));
		for (int i = 0; i < 3; i++) begin
			prog.push_back(encode(soc_pkg::LDI, stored[i]));
			prog.push_back(encode(soc_pkg::ST, 8'(8'h10 + i)));
		end
		for (int i = 2; i >= 0; i--) begin // Reverse order
			prog.push_back(encode(soc_pkg::LD, 8'(8'h10 + i)));
			prog.push_back(encode(soc_pkg::ST, 8'(8'h80 + 2 * i)));
		end
		prog.push_back(encode(soc_pkg::HALT, 8'h00));
		load_program();
		wait_done(2000);
		check_value("ram byte 0 on port 0", 24'(gpio_out.port0), 24'(stored[0]));
		check_value("ram byte 1 on port 1", 24'(gpio_out.port1), 24'(stored[1]));
		check_value("ram byte 2 on port 2", 24'(gpio_out.port2), 24'(stored[2]));
		check_value("all directions", gpio_oe, 24'hFFFFFF);
	endtask

	task automatic gpio_readback();
		logic [7:0] pin;
		logic [7:0] expected;
		pin = rand_bits(8);
		expected = pin + 8'h5A;
		@(posedge clk);
		gpio_in.port1 <= pin;
		prog.push_back(encode(soc_pkg::LDI, 8'hFF));
		prog.push_back(encode(soc_pkg::ST, 8'h85));
		prog.push_back(encode(soc_pkg::LD, 8'h82)); // Synchronizer has filled by now
		prog.push_back(encode(soc_pkg::ADD, 8'h5A));
		prog.push_back(encode(soc_pkg::ST, 8'h84));
		prog.push_back(encode(soc_pkg::HALT, 8'h00));
		load_program();
		wait_done(2000);
		check_value("port 1 input plus 5A", 24'(gpio_out.port2), 24'(expected));
		check_value("port 1 direction", 24'(gpio_oe.port1), 24'h00);
	endtask

	task automatic counted_loop();
		logic [7:0] count;
		count = (rand_bits(4) % 8'd15) + 8'd1;
		prog.push_back(encode(soc_pkg::LDI, 8'h00));
		prog.push_back(encode(soc_pkg::ST, 8'h20)); // Iterations
		prog.push_back(encode(soc_pkg::LDI, count));
		prog.push_back(encode(soc_pkg::ST, 8'h21)); // Down counter
		prog.push_back(encode(soc_pkg::LD, 8'h20)); // Loop at 4
		prog.push_back(encode(soc_pkg::ADD, 8'h01));
		prog.push_back(encode(soc_pkg::ST, 8'h20));
		prog.push_back(encode(soc_pkg::LD, 8'h21));
		prog.push_back(encode(soc_pkg::SUB, 8'h01));
		prog.push_back(encode(soc_pkg::ST, 8'h21));
		prog.push_back(encode(soc_pkg::JZ, 8'd12));
		prog.push_back(encode(soc_pkg::JMP, 8'd4));
		prog.push_back(encode(soc_pkg::LDI, 8'hFF));
		prog.push_back(encode(soc_pkg::ST, 8'h81));
		prog.push_back(encode(soc_pkg::LD, 8'h20));
		prog.push_back(encode(soc_pkg::ST, 8'h80));
		prog.push_back(encode(soc_pkg::HALT, 8'h00));
		load_program();
		wait_done(4000);
		check_value("loop count on port 0", 24'(gpio_out.port0), 24'(count));
	endtask

	task automatic illegal_opcode();
		logic [7:0] first;
		first = rand_bits(8);
		prog.push_back(encode(soc_pkg::LDI, 8'hFF));
		prog.push_back(encode(soc_pkg::ST, 8'h81));
		prog.push_back(encode(soc_pkg::LDI, first));
		prog.push_back(encode(soc_pkg::ST, 8'h80));
		prog.push_back({4'hB, 8'h00}); // Illegal opcode
		prog.push_back(encode(soc_pkg::LDI, ~first));
		prog.push_back(encode(soc_pkg::ST, 8'h80));
		prog.push_back(encode(soc_pkg::HALT, 8'h00));
		load_program();
		wait_done(2000);
		repeat (40) @(negedge clk); // Long enough for the rest of the program
		check_value("trap", 24'(trap), 24'h1);
		check_value("halted after trap", 24'(halted), 24'h0);
		check_value("port 0 after trap", 24'(gpio_out.port0), 24'(first));
	endtask

	initial begin
		lfsr_state = 32'h8868;
		reset = 1'b1;
		prog_load = '0;
		gpio_in = '0;
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		alu_chain();
		ram_round_trip();
		gpio_readback();
		counted_loop();
		illegal_opcode();
		reset_defaults(); // Trap, outputs and directions are set beforehand
		$display("Simulation passed");
		$finish;
	end

endmodule

// ==== flist.f ====
design/soc_pkg.sv
design/clock_enable.sv
design/cpu_control.sv
design/cpu_datapath.sv
design/memory_map.sv
design/gpio_ports.sv
design/soc_top.sv
dv/soc_tb.sv

// ==== Makefile ====
TOP := soc_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --timescale 1ns/1ps -Wno-fatal -f flist.f \
		--top-module $(TOP) -o $(TOP)

run: compile
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Simulation passed"

clean:
	rm -rf obj_dir
